//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

	localparam int CMD_W   = 8;
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int FRAME_W = CMD_W + ADDR_W + DATA_W; // 72
	localparam int CNT_W   = 8;

	// Command framings on the wire
	typedef enum logic [2:0] {
		CMD_ONLY,       // command
		CMD_READ,       // command, read
		CMD_ADDR_READ,  // command, address, dummy, read
		CMD_WRITE,      // command, write
		CMD_ADDR_WRITE, // command, address, write
		CMD_ADDR        // command, address
	} cmd_type_e;

	typedef logic [DATA_W-1:0] spi_word_t;

	typedef struct packed {
		cmd_type_e         cmd_type;
		logic [CMD_W-1:0]  command;
		logic [ADDR_W-1:0] address;
		spi_word_t         wdata;
		logic [6:0]        nbits;        // Payload bits, 8 to 32
		logic [3:0]        dummy_cycles;
		logic              addr4;        // 32-bit address
	} spi_req_t;

	typedef struct packed {
		logic [FRAME_W-1:0] tx_str;      // Left-justified, MSB out first
		logic [CNT_W-1:0]   tx_bits;
		logic [CNT_W-1:0]   skip_cycles; // Dummy clocks before read
		logic [CNT_W-1:0]   rx_bits;
		logic [CNT_W-1:0]   sclk_cycles;
	} frame_plan_t;

	// Payload byte order, low byte first on the wire
	function automatic spi_word_t swap_bytes(input spi_word_t w);
		spi_word_t s;
		for (int i = 0; i < DATA_W / 8; i++) begin
			s[8*i +: 8] = w[DATA_W - 8*(i+1) +: 8];
		end
		return s;
	endfunction

endpackage

`default_nettype wire

//--- spi_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module spi_ctrl import spi_pkg::*; (
	input  wire       rst,
	input  wire       clk,
	input  spi_req_t  req,
	input  wire       req_valid,
	input  wire       plan_done,
	input  wire       op_done,
	input  spi_word_t rx_word,
	output spi_req_t  req_q,
	output logic      setup_start,
	output logic      op_start,
	output logic      sclk_en,
	output logic      ss,
	output logic      ready,
	output spi_word_t rdata
);

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		TRANSFER
	} state_e;

	state_e state;
	logic   read_flag; // Current req_valid level already taken
	logic   accept;

	assign accept = (state == IDLE) && req_valid && !read_flag;

	// Request is held by the host only while req_valid is high
	always_ff @(posedge rst) begin
		if (accept) begin
			req_q <= req;
		end
	end

	// Cleared only once req_valid has dropped
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			read_flag <= 1'b0;
		end else if (accept) begin
			read_flag <= 1'b1;
		end else if (!req_valid) begin
			read_flag <= 1'b0;
		end
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state       <= IDLE;
			setup_start <= 1'b0;
			op_start    <= 1'b0;
			sclk_en     <= 1'b0;
			ss          <= 1'b1;
			ready       <= 1'b1;
			rdata       <= '0;
		end else begin
			setup_start <= 1'b0;
			op_start    <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						setup_start <= 1'b1;
						ready       <= 1'b0;
						rdata       <= '0; // Old result dropped
						state       <= SETUP;
					end
				end
				SETUP: begin
					if (plan_done) begin
						op_start <= 1'b1;
						sclk_en  <= 1'b1;
						ss       <= 1'b0;
						state    <= TRANSFER;
					end
				end
				TRANSFER: begin
					if (op_done) begin
						sclk_en <= 1'b0;
						ss      <= 1'b1;
						ready   <= 1'b1;
						rdata   <= rx_word;
						state   <= IDLE;
					end
				end
				default: begin
					sclk_en <= 1'b0;
					ss      <= 1'b1;
					ready   <= 1'b1;
					state   <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- frame_builder.sv
`timescale 1ns/10ps
`default_nettype none

module frame_builder import spi_pkg::*; (
	input  wire         rst,
	input  wire         clk,
	input  spi_req_t    req_q,
	input  wire         setup_start,
	output frame_plan_t plan,
	output logic        plan_done
);

	frame_plan_t plan_d;
	spi_word_t   wswap;
	logic [ADDR_W-1:0]          addr_lj;   // Address left-justified
	logic [ADDR_W+DATA_W-1:0]   addr_data; // Address then payload
	logic [CNT_W-1:0]           addr_bits;
	logic [CNT_W-1:0]           data_bits;

	assign wswap     = swap_bytes(req_q.wdata);
	assign addr_bits = req_q.addr4 ? CNT_W'(32) : CNT_W'(24);
	assign data_bits = CNT_W'(req_q.nbits);
	assign addr_lj   = req_q.addr4 ? req_q.address : {req_q.address[23:0], 8'h00};

	// Payload follows the address directly, also for 24-bit addresses
	assign addr_data = req_q.addr4 ? {req_q.address, wswap}
	                               : {req_q.address[23:0], wswap, 8'h00};

	always_comb begin
		plan_d             = '0;
		plan_d.tx_str      = {req_q.command, {(ADDR_W + DATA_W){1'b0}}};
		plan_d.tx_bits     = CNT_W'(CMD_W);
		case (req_q.cmd_type)
			CMD_READ: begin
				plan_d.rx_bits = data_bits;
			end
			CMD_ADDR_READ: begin
				plan_d.tx_str      = {req_q.command, addr_lj, {DATA_W{1'b0}}};
				plan_d.tx_bits     = CNT_W'(CMD_W) + addr_bits;
				plan_d.skip_cycles = CNT_W'(req_q.dummy_cycles);
				plan_d.rx_bits     = data_bits;
			end
			CMD_WRITE: begin
				plan_d.tx_str  = {req_q.command, wswap, {ADDR_W{1'b0}}};
				plan_d.tx_bits = CNT_W'(CMD_W) + data_bits;
			end
			CMD_ADDR_WRITE: begin
				plan_d.tx_str  = {req_q.command, addr_data};
				plan_d.tx_bits = CNT_W'(CMD_W) + addr_bits + data_bits;
			end
			CMD_ADDR: begin
				plan_d.tx_str  = {req_q.command, addr_lj, {DATA_W{1'b0}}};
				plan_d.tx_bits = CNT_W'(CMD_W) + addr_bits;
			end
			default: ; // CMD_ONLY and unused codes send the command alone
		endcase
		plan_d.sclk_cycles = plan_d.tx_bits + plan_d.skip_cycles + plan_d.rx_bits;
	end

	always_ff @(posedge rst) begin
		if (setup_start) begin
			plan <= plan_d;
		end
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			plan_done <= 1'b0;
		end else begin
			plan_done <= setup_start;
		end
	end

endmodule

`default_nettype wire

//--- sclk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sclk_gen import spi_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL               = 0
) (
	input  wire             rst,
	input  wire             clk,
	input  wire [CNT_W-1:0] sclk_cycles,
	input  wire             op_start,
	input  wire             sclk_en,
	output logic            lead_edge,
	output logic            trail_edge,
	output logic            sclk_int,
	output logic            op_done
);

	localparam int   HALF_W   = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
	localparam logic IDLE_LVL = 1'(CPOL);

	logic [HALF_W-1:0] half_cnt;
	logic [CNT_W:0]    edges_left; // Two edges per serial clock
	logic              half_end;

	assign half_end = (half_cnt == HALF_W'(CLKS_PER_HALF_SCLK - 1));

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			half_cnt   <= '0;
			edges_left <= '0;
			sclk_int   <= IDLE_LVL;
			lead_edge  <= 1'b0;
			trail_edge <= 1'b0;
			op_done    <= 1'b0;
		end else begin
			lead_edge  <= 1'b0;
			trail_edge <= 1'b0;
			op_done    <= trail_edge && (edges_left == '0); // After the last trailing edge
			if (op_start) begin
				edges_left <= {sclk_cycles, 1'b0};
				half_cnt   <= '0;
				sclk_int   <= IDLE_LVL;
			end else if (!sclk_en) begin
				edges_left <= '0;
				half_cnt   <= '0;
				sclk_int   <= IDLE_LVL;
			end else if (edges_left != '0) begin
				if (half_end) begin
					half_cnt   <= '0;
					sclk_int   <= ~sclk_int;
					edges_left <= edges_left - 1'b1;
					lead_edge  <= ~edges_left[0]; // Even count left means leading
					trail_edge <= edges_left[0];
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- spi_shift.sv
`timescale 1ns/10ps
`default_nettype none

module spi_shift import spi_pkg::*; #(
	parameter int CPHA = 0
) (
	input  wire         rst,
	input  wire         clk,
	input  wire         load,
	input  frame_plan_t plan,
	input  wire         sclk_en,
	input  wire         lead_edge,
	input  wire         trail_edge,
	input  wire         miso,
	output logic        mosi,
	output spi_word_t   rx_word
);

	// CPHA 1 drives on leading edges, CPHA 0 on trailing ones
	localparam bit OUT_ON_LEAD = (CPHA != 0);

	logic [FRAME_W-1:0] tx_sr;
	spi_word_t          rx_sr;
	spi_word_t          rx_just;
	logic [CNT_W-1:0]   tx_cnt;  // Bits still to drive
	logic [CNT_W-1:0]   pre_cnt; // Sample edges before read data
	logic [CNT_W-1:0]   rx_left;
	logic [CNT_W-1:0]   rx_len;
	logic               out_edge;
	logic               samp_edge;
	logic               tx_step;
	logic               rx_step;

	assign out_edge  = sclk_en && (OUT_ON_LEAD ? lead_edge : trail_edge);
	assign samp_edge = sclk_en && (OUT_ON_LEAD ? trail_edge : lead_edge);
	assign tx_step   = out_edge && (tx_cnt != '0);
	assign rx_step   = samp_edge && (pre_cnt == '0) && (rx_left != '0);

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			mosi    <= 1'b0;
			tx_cnt  <= '0;
			pre_cnt <= '0;
			rx_left <= '0;
			rx_len  <= '0;
		end else if (load) begin
			pre_cnt <= plan.tx_bits + plan.skip_cycles;
			rx_left <= plan.rx_bits;
			rx_len  <= plan.rx_bits;
			if (OUT_ON_LEAD) begin
				mosi   <= 1'b0;
				tx_cnt <= plan.tx_bits;
			end else begin
				mosi   <= plan.tx_str[FRAME_W-1]; // First bit ahead of any clock
				tx_cnt <= plan.tx_bits - 1'b1;
			end
		end else if (!sclk_en) begin
			mosi <= 1'b0;
		end else begin
			if (out_edge) begin
				mosi <= tx_step ? tx_sr[FRAME_W-1] : 1'b0;
			end
			if (tx_step) begin
				tx_cnt <= tx_cnt - 1'b1;
			end
			if (samp_edge && (pre_cnt != '0)) begin
				pre_cnt <= pre_cnt - 1'b1;
			end
			if (rx_step) begin
				rx_left <= rx_left - 1'b1;
			end
		end
	end

	always_ff @(posedge rst) begin
		if (load) begin
			tx_sr <= OUT_ON_LEAD ? plan.tx_str : (plan.tx_str << 1);
			rx_sr <= '0;
		end else begin
			if (tx_step) begin
				tx_sr <= tx_sr << 1;
			end
			if (rx_step) begin
				rx_sr <= {rx_sr[DATA_W-2:0], miso};
			end
		end
	end

	// First received byte moved to the top, then swapped to the bottom
	assign rx_just = rx_sr << (DATA_W - int'(rx_len));
	assign rx_word = swap_bytes(rx_just);

endmodule

`default_nettype wire

//--- spi_flash_master.sv
`timescale 1ns/10ps
`default_nettype none

module spi_flash_master import spi_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL               = 0,
	parameter int CPHA               = 0
) (
	input  wire       rst,
	input  wire       clk,
	input  spi_req_t  req,
	input  wire       req_valid,
	output logic      ready,
	output spi_word_t rdata,
	output logic      sclk,
	output logic      ss,
	output logic      mosi,
	input  wire       miso
);

	spi_req_t    req_q;
	frame_plan_t plan;
	spi_word_t   rx_word;
	logic        setup_start;
	logic        plan_done;
	logic        op_start;
	logic        sclk_en;
	logic        lead_edge;
	logic        trail_edge;
	logic        sclk_int;
	logic        op_done;

	spi_ctrl ctrl0 (
		.rst         (rst),
		.clk         (clk),
		.req         (req),
		.req_valid   (req_valid),
		.plan_done   (plan_done),
		.op_done     (op_done),
		.rx_word     (rx_word),
		.req_q       (req_q),
		.setup_start (setup_start),
		.op_start    (op_start),
		.sclk_en     (sclk_en),
		.ss          (ss),
		.ready       (ready),
		.rdata       (rdata)
	);

	frame_builder build0 (
		.rst         (rst),
		.clk         (clk),
		.req_q       (req_q),
		.setup_start (setup_start),
		.plan        (plan),
		.plan_done   (plan_done)
	);

	sclk_gen #(
		.CLKS_PER_HALF_SCLK (CLKS_PER_HALF_SCLK),
		.CPOL               (CPOL)
	) sclk_gen0 (
		.rst         (rst),
		.clk         (clk),
		.sclk_cycles (plan.sclk_cycles),
		.op_start    (op_start),
		.sclk_en     (sclk_en),
		.lead_edge   (lead_edge),
		.trail_edge  (trail_edge),
		.sclk_int    (sclk_int),
		.op_done     (op_done)
	);

	spi_shift #(
		.CPHA (CPHA)
	) shift0 (
		.rst        (rst),
		.clk        (clk),
		.load       (plan_done),
		.plan       (plan),
		.sclk_en    (sclk_en),
		.lead_edge  (lead_edge),
		.trail_edge (trail_edge),
		.miso       (miso),
		.mosi       (mosi),
		.rx_word    (rx_word)
	);

	// Pin register, rests at the idle polarity
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			sclk <= 1'(CPOL);
		end else begin
			sclk <= sclk_int;
		end
	end

endmodule

`default_nettype wire

//--- spi_chk.sv
`timescale 1ns/10ps
`default_nettype none

module spi_chk #(
	parameter int CPOL = 0
) (
	input wire rst,
	input wire clk,
	input wire ready,
	input wire ss,
	input wire sclk
);

	// Done and an active chip select never overlap
	a_ready_ss: assert property (@(posedge rst) disable iff (clk) !(ready && !ss))
		else $error("ready high while ss is low");

	a_sclk_idle: assert property (@(posedge rst) disable iff (clk) ss |-> (sclk == 1'(CPOL)))
		else $error("sclk left its idle level while ss is high");

	// ss may only rise together with ready
	a_ss_hold: assert property (@(posedge rst) disable iff (clk)
		(!ss && !ready) |=> (!ss || ready))
		else $error("ss rose before ready");

endmodule

bind spi_flash_master spi_chk #(
	.CPOL (CPOL)
) chk0 (
	.rst   (rst),
	.clk   (clk),
	.ready (ready),
	.ss    (ss),
	.sclk  (sclk)
);

`default_nettype wire

//--- tb_spi_flash_master.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_flash_master import spi_pkg::*; ();

	localparam int TIMEOUT = 2000; // Clocks per wait

	typedef struct packed {
		logic [FRAME_W-1:0] bits;    // Expected mosi string, left-justified
		logic [CNT_W-1:0]   tx_bits;
		logic [CNT_W-1:0]   skip;
		logic [CNT_W-1:0]   clocks;
		spi_word_t          rdata;
	} expect_t;

	logic      rst = 1'b0; // Clock port
	logic      clk = 1'b1; // Reset port
	spi_req_t  req;
	logic      req_valid;
	logic      miso = 1'b0;
	logic      ready;
	logic      sclk;
	logic      ss;
	logic      mosi;
	spi_word_t rdata;

	logic [31:0] lfsr = 32'h0ed8_55cf;
	expect_t     exp_q[$];
	expect_t     cur_exp;
	int          done_cnt = 0;

	// Flash responder state
	spi_word_t          resp_word;
	int                 read_start;
	int                 rise_cnt = 0;
	int                 rd_idx = 0;
	logic [FRAME_W-1:0] rec_bits = '0;
	logic               sclk_q = 1'b0;
	logic               ss_q = 1'b1;
	logic               ss_seen = 1'b1;

	always #4 rst = ~rst;

	spi_flash_master #(
		.CLKS_PER_HALF_SCLK (2),
		.CPOL               (0),
		.CPHA               (0)
	) dut0 (
		.rst       (rst),
		.clk       (clk),
		.req       (req),
		.req_valid (req_valid),
		.ready     (ready),
		.rdata     (rdata),
		.sclk      (sclk),
		.ss        (ss),
		.mosi      (mosi),
		.miso      (miso)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Bit i of the result comes from step i
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	function automatic expect_t predict_transfer(input spi_req_t r, input spi_word_t resp);
		expect_t e;
		int      pos;
		int      abits;
		int      nrx;
		logic    has_addr;
		logic    has_wr;
		e        = '0;
		pos      = FRAME_W;
		has_addr = r.cmd_type inside {CMD_ADDR_READ, CMD_ADDR_WRITE, CMD_ADDR};
		has_wr   = r.cmd_type inside {CMD_WRITE, CMD_ADDR_WRITE};
		nrx      = (r.cmd_type inside {CMD_READ, CMD_ADDR_READ}) ? int'(r.nbits) : 0;
		abits    = r.addr4 ? 32 : 24;
		for (int i = CMD_W - 1; i >= 0; i--) begin
			pos--;
			e.bits[pos] = r.command[i];
		end
		if (has_addr) begin
			for (int i = abits - 1; i >= 0; i--) begin
				pos--;
				e.bits[pos] = r.address[i];
			end
		end
		if (has_wr) begin
			for (int b = 0; b < int'(r.nbits) / 8; b++) begin
				for (int i = 7; i >= 0; i--) begin // Low byte first, MSB first
					pos--;
					e.bits[pos] = r.wdata[8*b + i];
				end
			end
		end
		e.tx_bits = CNT_W'(FRAME_W - pos);
		e.skip    = (r.cmd_type == CMD_ADDR_READ) ? CNT_W'(r.dummy_cycles) : '0;
		e.clocks  = e.tx_bits + e.skip + CNT_W'(nrx);
		for (int i = 0; i < nrx; i++) begin
			e.rdata[i] = resp[i]; // Bytes not read stay zero
		end
		return e;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Only the top count bits are compared
	task automatic check_frame(input logic [FRAME_W-1:0] got, input logic [FRAME_W-1:0] exp,
		input int count, input string what);
		logic [FRAME_W-1:0] mask;
		mask = '0;
		for (int i = 0; i < count; i++) begin
			mask[FRAME_W-1-i] = 1'b1;
		end
		if ((got & mask) !== (exp & mask)) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h (%0d bits)",
				$time, what, got & mask, exp & mask, count));
		end
	endtask

	task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_word(input spi_word_t got, input spi_word_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic wait_ready(input logic level);
		int n;
		n = 0;
		while (ready !== level) begin
			@(posedge rst);
			n++;
			if (n > TIMEOUT) begin
				fail_run($sformatf("Timed out waiting for ready to become %b", level));
			end
		end
	endtask

	task automatic wait_done(input int target);
		int n;
		n = 0;
		while (done_cnt < target) begin
			@(posedge rst);
			n++;
			if (n > TIMEOUT) begin
				fail_run("Timed out waiting for a finished transfer to be compared");
			end
		end
	endtask

	task automatic make_req(input cmd_type_e t, input int nbits, input logic a4,
		output spi_req_t r);
		logic [31:0] v;
		r          = '0;
		r.cmd_type = t;
		draw_bits(8, v);
		r.command = v[7:0];
		draw_bits(32, v);
		r.address = v;
		draw_bits(32, v);
		r.wdata = v;
		draw_bits(4, v);
		r.dummy_cycles = v[3:0];
		r.nbits        = 7'(nbits);
		r.addr4        = a4;
	endtask

	task automatic queue_request(input spi_req_t r);
		logic [31:0] resp;
		expect_t     e;
		draw_bits(32, resp);
		e = predict_transfer(r, resp);
		exp_q.push_back(e);
		resp_word  = resp;
		read_start = int'(e.tx_bits) + int'(e.skip);
		@(posedge rst);
		req       <= r;
		req_valid <= 1'b1;
	endtask

	task automatic run_transfer(input spi_req_t r);
		int target;
		target = done_cnt + 1;
		queue_request(r);
		wait_ready(1'b0);
		req_valid <= 1'b0; // ready has fallen
		wait_ready(1'b1);
		wait_done(target);
	endtask

	// Flash responder, follows the pins one clock late
	always @(posedge rst) begin
		sclk_q <= sclk;
		ss_q   <= ss;
		if (clk || ss) begin
			miso <= 1'b0;
		end else if (ss_q) begin
			rise_cnt <= 0; // ss just fell
			rd_idx   <= 0;
			rec_bits <= '0;
		end else begin
			if (sclk && !sclk_q) begin
				if (rise_cnt < FRAME_W) begin
					rec_bits[FRAME_W-1-rise_cnt] <= mosi;
				end
				rise_cnt <= rise_cnt + 1;
			end
			if (!sclk && sclk_q) begin // Output edge
				if (rise_cnt >= read_start && rd_idx < DATA_W) begin
					miso   <= resp_word[8*(rd_idx/8) + 7 - rd_idx%8];
					rd_idx <= rd_idx + 1;
				end else begin
					miso <= 1'b0;
				end
			end
		end
	end

	// Compare on the first clock with ss back high
	always @(posedge rst) begin
		ss_seen <= ss;
		if (!clk && ss && !ss_seen) begin
			if (exp_q.size() == 0) begin
				fail_run("A transfer ran with no request pending");
			end else begin
				cur_exp = exp_q.pop_front();
				check_frame(rec_bits, cur_exp.bits,
					(cur_exp.clocks < FRAME_W) ? int'(cur_exp.clocks) : FRAME_W, "mosi bits");
				check_count(CNT_W'(rise_cnt), cur_exp.clocks, "sclk pulses");
				check_word(rdata, cur_exp.rdata, "rdata");
				done_cnt <= done_cnt + 1;
			end
		end
	end

	initial begin
		spi_req_t r;
		int       target;
		req        = '0;
		req_valid  = 1'b0;
		resp_word  = '0;
		read_start = 0;
		repeat (8) @(posedge rst);
		clk <= 1'b0;
		@(posedge rst);
		check_level(ready, 1'b1, "ready after reset");
		check_level(ss, 1'b1, "ss after reset");
		check_level(sclk, 1'b0, "sclk after reset");
		check_level(mosi, 1'b0, "mosi after reset");
		check_word(rdata, '0, "rdata after reset");

		for (int a = 0; a < 2; a++) begin
			make_req(CMD_ONLY, 8, a[0], r);
			run_transfer(r);
			make_req(CMD_ADDR, 8, a[0], r);
			run_transfer(r);
		end

		for (int n = 8; n <= 32; n += 8) begin
			make_req(CMD_WRITE, n, 1'b0, r);
			run_transfer(r);
			make_req(CMD_ADDR_WRITE, n, 1'b0, r);
			run_transfer(r);
			make_req(CMD_ADDR_WRITE, n, 1'b1, r);
			run_transfer(r);
		end

		for (int k = 0; k < 8; k++) begin
			make_req(CMD_READ, 8 * (k % 4 + 1), k[0], r);
			run_transfer(r);
			make_req(CMD_ADDR_READ, 8 * (k % 4 + 1), k[1], r);
			run_transfer(r);
		end

		// Level held past the end
		make_req(CMD_ADDR_READ, 16, 1'b0, r);
		target = done_cnt + 1;
		queue_request(r);
		wait_ready(1'b0);
		wait_ready(1'b1);
		wait_done(target);
		repeat (40) begin
			@(posedge rst);
			check_level(ss, 1'b1, "ss while req_valid stays high");
		end
		req_valid <= 1'b0;
		repeat (2) @(posedge rst);
		// Raised again and held through the new transfer
		make_req(CMD_WRITE, 32, 1'b0, r);
		queue_request(r);
		wait_ready(1'b0);
		wait_ready(1'b1);
		wait_done(target + 1);
		repeat (40) begin
			@(posedge rst);
			check_level(ss, 1'b1, "ss after the new transfer");
		end
		req_valid <= 1'b0;

		if (exp_q.size() != 0) begin
			fail_run("An expected transfer never ran");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- src.f
spi_pkg.sv
spi_ctrl.sv
frame_builder.sv
sclk_gen.sv
spi_shift.sv
spi_flash_master.sv
spi_chk.sv
tb_spi_flash_master.sv

//--- Makefile
TOP := tb_spi_flash_master

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
